/* fb_pkg.sv */
package fb_pkg;

	// Raster geometry, kept tiny for simulation
	localparam int H_ACTIVE = 8;
	localparam int H_TOTAL  = 12;
	localparam int V_ACTIVE = 4;
	localparam int V_TOTAL  = 6;

	// Sync windows inside blanking, start inclusive and end exclusive
	localparam int H_SYNC_START = 9;
	localparam int H_SYNC_END   = 11;
	localparam int V_SYNC_START = 5;
	localparam int V_SYNC_END   = 6;

	localparam int POS_W  = 4;  // x and y counters
	localparam int WORD_W = 64;
	localparam int ADDR_W = 16; // Word address
	localparam int RGB_W  = 24;

	localparam logic [ADDR_W-1:0] FB_BASE = 16'h0100;
	localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE / 2; // Two pixels per word
	localparam int REQ_CNT_W   = $clog2(FRAME_WORDS + 1);

	// Prefetch FIFO
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W = 3;
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
	localparam int BUDGET_W   = FIFO_CNT_W + 1; // Holds FIFO count plus in-flight count

	localparam logic [RGB_W-1:0] BORDER_RGB    = 24'h0000ff; // Blue
	localparam logic [RGB_W-1:0] UNDERFLOW_RGB = 24'hff0000; // Red

	typedef enum logic {
		FETCH_RUN,
		FETCH_FLUSH // Draining replies from the previous frame
	} fetch_state_e;

endpackage

/* sync_gen.sv */
module sync_gen import fb_pkg::*; (
	input  logic             fbclk,
	input  logic             fbclk_rst_b,
	output logic [POS_W-1:0] x,
	output logic [POS_W-1:0] y,
	output logic             hs,
	output logic             vs,
	output logic             border,
	output logic             frame_end
);

	logic x_last;
	logic y_last;
	logic h_active;
	logic v_active;

	assign x_last = (x == POS_W'(H_TOTAL - 1));
	assign y_last = (y == POS_W'(V_TOTAL - 1));

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			x <= '0;
			y <= POS_W'(V_ACTIVE); // First line of vertical blanking
		end else begin
			if (x_last) begin
				x <= '0;
				if (y_last) begin
					y <= '0;
				end else begin
					y <= y + 1'b1;
				end
			end else begin
				x <= x + 1'b1;
			end
		end
	end

	assign h_active = (x < POS_W'(H_ACTIVE));
	assign v_active = (y < POS_W'(V_ACTIVE));

	// Blanking level, drives border colour and data-enable downstream
	assign border = !(h_active && v_active);

	// Active high sync pulses
	assign hs = (x >= POS_W'(H_SYNC_START)) && (x < POS_W'(H_SYNC_END));
	assign vs = (y >= POS_W'(V_SYNC_START)) && (y < POS_W'(V_SYNC_END));

	// One cycle at the very start of vertical blanking
	assign frame_end = (x == '0) && (y == POS_W'(V_ACTIVE));

endmodule

/* pixel_fetch.sv */
module pixel_fetch import fb_pkg::*; (
	input  logic              fbclk,
	input  logic              fbclk_rst_b,
	input  logic              frame_end,
	input  logic              word_pop,
	input  logic [WORD_W-1:0] mem_data,
	input  logic              mem_data_valid,
	output logic              mem_rd_req,
	output logic [ADDR_W-1:0] mem_rd_addr,
	output logic [WORD_W-1:0] word,
	output logic              word_avail
);

	fetch_state_e state;

	logic [REQ_CNT_W-1:0]  req_cnt;      // Words requested this frame
	logic [FIFO_CNT_W-1:0] inflight_cnt; // Issued, not yet written or dropped
	logic [FIFO_CNT_W-1:0] fifo_cnt;
	logic [BUDGET_W-1:0]   budget;

	// Reply capture stage, one cycle ahead of the FIFO write
	logic [WORD_W-1:0] rx_data;
	logic              rx_valid;

	logic [WORD_W-1:0]     fifo_mem [FIFO_DEPTH];
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic                  push;
	logic                  pop;

	assign budget = {1'b0, fifo_cnt} + {1'b0, inflight_cnt};

	// Only ask when the FIFO is sure to have room for the reply
	assign mem_rd_req = (state == FETCH_RUN) && !frame_end &&
		(req_cnt < REQ_CNT_W'(FRAME_WORDS)) &&
		(budget < BUDGET_W'(FIFO_DEPTH));

	// Replies landing during a flush belong to the old frame
	assign push = rx_valid && (state == FETCH_RUN) && !frame_end;
	assign pop  = word_pop && word_avail && !frame_end; // Empty pop ignored

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			state        <= FETCH_FLUSH; // Nothing in flight, leaves on the next cycle
			mem_rd_addr  <= FB_BASE;
			req_cnt      <= '0;
			inflight_cnt <= '0;
			rx_valid     <= 1'b0;
		end else begin
			rx_valid     <= mem_data_valid;
			inflight_cnt <= inflight_cnt + FIFO_CNT_W'(mem_rd_req) - FIFO_CNT_W'(rx_valid);

			if (frame_end) begin
				state       <= FETCH_FLUSH;
				mem_rd_addr <= FB_BASE;
				req_cnt     <= '0;
			end else begin
				// Last stale reply has left the capture stage
				if ((state == FETCH_FLUSH) && (inflight_cnt == '0)) begin
					state <= FETCH_RUN;
				end
				if (mem_rd_req) begin
					mem_rd_addr <= mem_rd_addr + 1'b1;
					req_cnt     <= req_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge fbclk) begin
		if (mem_data_valid) begin
			rx_data <= mem_data;
		end
	end

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (frame_end) begin // Frame restart empties the FIFO
				wr_ptr   <= '0;
				rd_ptr   <= '0;
				fifo_cnt <= '0;
			end else begin
				if (push) begin
					wr_ptr <= wr_ptr + 1'b1;
				end
				if (pop) begin
					rd_ptr <= rd_ptr + 1'b1;
				end
				fifo_cnt <= fifo_cnt + FIFO_CNT_W'(push) - FIFO_CNT_W'(pop);
			end
		end
	end

	always_ff @(posedge fbclk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= rx_data;
		end
	end

	// Head of FIFO, valid whenever word_avail is high
	assign word       = fifo_mem[rd_ptr];
	assign word_avail = (fifo_cnt != '0);

endmodule

/* pixel_format.sv */
module pixel_format import fb_pkg::*; (
	input  logic              fbclk,
	input  logic              fbclk_rst_b,
	input  logic [POS_W-1:0]  x,
	input  logic [POS_W-1:0]  y,
	input  logic              hs,
	input  logic              vs,
	input  logic              border,
	input  logic [WORD_W-1:0] word,
	input  logic              word_avail,
	output logic              word_pop,
	output logic [RGB_W-1:0]  dvi_rgb,
	output logic              dvi_de,
	output logic              dvi_hs,
	output logic              dvi_vs,
	output logic              fb_underflow
);

	logic             half;       // Low half of the word is next
	logic             half_sel;
	logic             line_start;
	logic             starve;
	logic [RGB_W-1:0] pix_rgb;

	// First active pixel of a line always takes the high half
	assign line_start = (x == '0) && (y < POS_W'(V_ACTIVE));
	assign half_sel   = line_start ? 1'b0 : half;

	assign starve   = !border && !word_avail;
	assign word_pop = !border && half_sel; // Word done after its second pixel

	always_comb begin
		if (border) begin
			pix_rgb = BORDER_RGB;
		end else if (!word_avail) begin
			pix_rgb = UNDERFLOW_RGB;
		end else if (half_sel) begin
			pix_rgb = word[31:8];
		end else begin
			pix_rgb = word[63:40];
		end
	end

	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			half         <= 1'b0;
			dvi_de       <= 1'b0;
			dvi_hs       <= 1'b0;
			dvi_vs       <= 1'b0;
			fb_underflow <= 1'b0;
		end else begin
			if (!border) begin
				half <= !half_sel; // Toggles even when starved
			end
			dvi_de       <= !border;
			dvi_hs       <= hs;
			dvi_vs       <= vs;
			fb_underflow <= starve;
		end
	end

	always_ff @(posedge fbclk) begin
		dvi_rgb <= pix_rgb;
	end

endmodule

/* framebuffer.sv */
module framebuffer import fb_pkg::*; (
	input  logic              fbclk,
	input  logic              fbclk_rst_b,
	input  logic [WORD_W-1:0] mem_data,
	input  logic              mem_data_valid,
	output logic              mem_rd_req,
	output logic [ADDR_W-1:0] mem_rd_addr,
	output logic [RGB_W-1:0]  dvi_rgb,
	output logic              dvi_de,
	output logic              dvi_hs,
	output logic              dvi_vs,
	output logic              fb_underflow
);

	// Beam position and timing
	logic [POS_W-1:0] x;
	logic [POS_W-1:0] y;
	logic             hs;
	logic             vs;
	logic             border;
	logic             frame_end;

	// Fetch to formatter
	logic [WORD_W-1:0] word;
	logic              word_avail;
	logic              word_pop;

	sync_gen u_sync_gen (
		.fbclk       (fbclk),
		.fbclk_rst_b (fbclk_rst_b),
		.x           (x),
		.y           (y),
		.hs          (hs),
		.vs          (vs),
		.border      (border),
		.frame_end   (frame_end)
	);

	pixel_fetch u_pixel_fetch (
		.fbclk          (fbclk),
		.fbclk_rst_b    (fbclk_rst_b),
		.frame_end      (frame_end),
		.word_pop       (word_pop),
		.mem_data       (mem_data),
		.mem_data_valid (mem_data_valid),
		.mem_rd_req     (mem_rd_req),
		.mem_rd_addr    (mem_rd_addr),
		.word           (word),
		.word_avail     (word_avail)
	);

	pixel_format u_pixel_format (
		.fbclk        (fbclk),
		.fbclk_rst_b  (fbclk_rst_b),
		.x            (x),
		.y            (y),
		.hs           (hs),
		.vs           (vs),
		.border       (border),
		.word         (word),
		.word_avail   (word_avail),
		.word_pop     (word_pop),
		.dvi_rgb      (dvi_rgb),
		.dvi_de       (dvi_de),
		.dvi_hs       (dvi_hs),
		.dvi_vs       (dvi_vs),
		.fb_underflow (fb_underflow)
	);

endmodule

/* framebuffer_assert.sv */
module framebuffer_assert import fb_pkg::*; (
	input logic                  fbclk,
	input logic                  fbclk_rst_b,
	input logic                  mem_rd_req,
	input logic                  mem_data_valid,
	input logic [FIFO_CNT_W-1:0] fifo_cnt,
	input logic                  dvi_de,
	input logic                  dvi_hs,
	input logic                  dvi_vs,
	input logic                  fb_underflow
);

	timeunit 1ns;
	timeprecision 100ps;

	int                    fail_cnt = 0;
	logic [FIFO_CNT_W-1:0] outstanding; // Requests not yet answered on the bus
	logic                  reply_held;  // Reply in the fetch capture stage
	logic [BUDGET_W-1:0]   budget;

	// In-flight count rebuilt from the memory bus alone
	always_ff @(posedge fbclk or negedge fbclk_rst_b) begin
		if (!fbclk_rst_b) begin
			outstanding <= '0;
			reply_held  <= 1'b0;
		end else begin
			outstanding <= outstanding + FIFO_CNT_W'(mem_rd_req) - FIFO_CNT_W'(mem_data_valid);
			reply_held  <= mem_data_valid;
		end
	end

	assign budget = BUDGET_W'(fifo_cnt) + BUDGET_W'(outstanding) + BUDGET_W'(reply_held);

	// Each request needs a FIFO slot waiting for its reply
	req_in_budget: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		mem_rd_req |-> (budget < BUDGET_W'(FIFO_DEPTH)))
	else begin
		fail_cnt++;
		$error("Read request issued with FIFO plus in-flight count at depth");
	end

	underflow_in_active: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		fb_underflow |-> dvi_de)
	else begin
		fail_cnt++;
		$error("Underflow pulse outside the active region");
	end

	no_de_in_sync: assert property (@(posedge fbclk) disable iff (!fbclk_rst_b)
		(dvi_hs || dvi_vs) |-> !dvi_de) // Syncs sit in blanking only
	else begin
		fail_cnt++;
		$error("Data enable high during a sync pulse");
	end

endmodule

/* framebuffer_tb.sv */
module framebuffer_tb import fb_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int          N_FRAMES     = 6;
	localparam int          TEST_WORDS   = FRAME_WORDS + N_FRAMES; // Frame words, then stall flags
	localparam int          FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int          MAX_CYCLES   = N_FRAMES * FRAME_CYCLES + FRAME_CYCLES / 2;
	localparam int          DE_PER_FRAME = H_ACTIVE * V_ACTIVE;
	localparam int          HS_PER_FRAME = V_TOTAL * (H_SYNC_END - H_SYNC_START);
	localparam int          VS_PER_FRAME = H_TOTAL * (V_SYNC_END - V_SYNC_START);
	localparam logic [31:0] SEED         = 32'h4b10_df8e;

	logic              fbclk;
	logic              fbclk_rst_b;
	logic [WORD_W-1:0] mem_data;
	logic              mem_data_valid;
	logic              mem_rd_req;
	logic [ADDR_W-1:0] mem_rd_addr;
	logic [RGB_W-1:0]  dvi_rgb;
	logic              dvi_de;
	logic              dvi_hs;
	logic              dvi_vs;
	logic              fb_underflow;

	logic [WORD_W-1:0] tests [TEST_WORDS];

	// Beam position now, and the position the outputs show
	int   pos_x     = 0;
	int   pos_y     = V_ACTIVE;
	int   frame_idx = 0;
	int   out_x     = 0;
	int   out_y     = 0;
	int   out_frame = 0;
	logic out_valid = 1'b0;
	int   cyc       = 0;

	// In-order memory with per-request due cycle
	logic [ADDR_W-1:0] rd_addr_q [$];
	int                rd_due_q  [$];
	int                req_idx = 0; // Reads seen in this frame

	int de_cnt    = 0;
	int hs_cnt    = 0;
	int vs_cnt    = 0;
	int pix_err   = 0;
	int sync_err  = 0;
	int fetch_err = 0;

	framebuffer i_framebuffer (
		.fbclk          (fbclk),
		.fbclk_rst_b    (fbclk_rst_b),
		.mem_data       (mem_data),
		.mem_data_valid (mem_data_valid),
		.mem_rd_req     (mem_rd_req),
		.mem_rd_addr    (mem_rd_addr),
		.dvi_rgb        (dvi_rgb),
		.dvi_de         (dvi_de),
		.dvi_hs         (dvi_hs),
		.dvi_vs         (dvi_vs),
		.fb_underflow   (fb_underflow)
	);

	bind framebuffer framebuffer_assert u_fb_assert (
		.fbclk          (fbclk),
		.fbclk_rst_b    (fbclk_rst_b),
		.mem_rd_req     (mem_rd_req),
		.mem_data_valid (mem_data_valid),
		.fifo_cnt       (u_pixel_fetch.fifo_cnt),
		.dvi_de         (dvi_de),
		.dvi_hs         (dvi_hs),
		.dvi_vs         (dvi_vs),
		.fb_underflow   (fb_underflow)
	);

	initial begin
		fbclk          = 1'b0;
		fbclk_rst_b    = 1'b0;
		mem_data       = '0;
		mem_data_valid = 1'b0;
		void'($urandom(SEED));
		$readmemh("framebuffer_tests.mem", tests);
	end

	always #10 fbclk = !fbclk;

	function automatic logic is_stalled(int f);
		if (f < 0 || f >= N_FRAMES) begin
			return 1'b0;
		end
		return tests[FRAME_WORDS + f][0];
	endfunction

	// Two pixels per word with the high half first
	function automatic logic [RGB_W-1:0] expected_pixel(int px, int py);
		logic [WORD_W-1:0] w;
		w = tests[(py * H_ACTIVE + px) / 2];
		if (px % 2 == 0) begin
			return w[63:40];
		end
		return w[31:8];
	endfunction

	function automatic int total_errors();
		return pix_err + sync_err + fetch_err + i_framebuffer.u_fb_assert.fail_cnt;
	endfunction

	task automatic print_summary();
		$display("Errors: %0d pixel, %0d timing, %0d fetch, %0d assertion",
			pix_err, sync_err, fetch_err, i_framebuffer.u_fb_assert.fail_cnt);
	endtask

	task automatic track_reads();
		if (pos_x == 0 && pos_y == V_ACTIVE) begin // Fetch restarts here
			if (frame_idx > 0 && !is_stalled(frame_idx - 1) && req_idx != FRAME_WORDS) begin
				fetch_err++;
				$display("Fail at %0t: mem_rd_req count of frame %0d expected %0d, got %0d",
					$time, frame_idx - 1, FRAME_WORDS, req_idx);
			end
			req_idx = 0;
		end
		if (mem_rd_req) begin
			if (req_idx >= FRAME_WORDS) begin
				fetch_err++;
				$display("Read %0d in frame %0d goes past the frame end", req_idx, frame_idx);
			end
			if (mem_rd_addr != FB_BASE + ADDR_W'(req_idx)) begin
				fetch_err++;
				$display("Fail at %0t: mem_rd_addr expected %h, got %h",
					$time, FB_BASE + ADDR_W'(req_idx), mem_rd_addr);
			end
			rd_addr_q.push_back(mem_rd_addr);
			rd_due_q.push_back(cyc + 1 + int'($urandom % 32'd4)); // 1 to 4 cycles
			req_idx++;
		end
	endtask

	task automatic check_count(string name, int f, int exp_cnt, int got_cnt);
		if (got_cnt != exp_cnt) begin
			sync_err++;
			$display("Fail at %0t: %s count of frame %0d expected %0d, got %0d",
				$time, name, f, exp_cnt, got_cnt);
		end
	endtask

	task automatic check_pixel();
		logic             active;
		logic             exp_hs;
		logic             exp_vs;
		logic             exp_uf;
		logic [RGB_W-1:0] exp_rgb;
		active = (out_x < H_ACTIVE) && (out_y < V_ACTIVE);
		exp_hs = (out_x >= H_SYNC_START) && (out_x < H_SYNC_END);
		exp_vs = (out_y >= V_SYNC_START) && (out_y < V_SYNC_END);
		exp_uf = active && is_stalled(out_frame); // Starved frame is all red
		if (!active) begin
			exp_rgb = BORDER_RGB;
		end else if (exp_uf) begin
			exp_rgb = UNDERFLOW_RGB;
		end else begin
			exp_rgb = expected_pixel(out_x, out_y);
		end
		if (dvi_rgb !== exp_rgb) begin
			pix_err++;
			$display("Fail at %0t: dvi_rgb expected %h, got %h (frame %0d, x %0d, y %0d)",
				$time, exp_rgb, dvi_rgb, out_frame, out_x, out_y);
		end
		if (fb_underflow !== exp_uf) begin
			pix_err++;
			$display("Fail at %0t: fb_underflow expected %b, got %b", $time, exp_uf, fb_underflow);
		end
		if (dvi_de !== active) begin
			sync_err++;
			$display("Fail at %0t: dvi_de expected %b, got %b", $time, active, dvi_de);
		end
		if (dvi_hs !== exp_hs) begin
			sync_err++;
			$display("Fail at %0t: dvi_hs expected %b, got %b", $time, exp_hs, dvi_hs);
		end
		if (dvi_vs !== exp_vs) begin
			sync_err++;
			$display("Fail at %0t: dvi_vs expected %b, got %b", $time, exp_vs, dvi_vs);
		end
		de_cnt += int'(dvi_de === 1'b1);
		hs_cnt += int'(dvi_hs === 1'b1);
		vs_cnt += int'(dvi_vs === 1'b1);
	endtask

	always @(posedge fbclk) begin
		int off;
		cyc <= cyc + 1;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout: %0d cycles passed before frame %0d was reached", cyc, N_FRAMES);
			print_summary();
			$display("TEST RESULT: FAIL");
			$finish;
		end else begin
			if (cyc == 1) begin
				fbclk_rst_b <= 1'b1; // Two edges in reset
			end
			if (fbclk_rst_b) begin
				out_x     <= pos_x; // Outputs lag the beam by one cycle
				out_y     <= pos_y;
				out_frame <= frame_idx;
				out_valid <= 1'b1;
				if (pos_x == H_TOTAL - 1) begin
					pos_x <= 0;
					if (pos_y == V_TOTAL - 1) begin
						pos_y <= 0;
					end else begin
						pos_y <= pos_y + 1;
						if (pos_y + 1 == V_ACTIVE) begin
							frame_idx <= frame_idx + 1; // New frame at blanking start
						end
					end
				end else begin
					pos_x <= pos_x + 1;
				end

				mem_data_valid <= 1'b0;
				if (rd_addr_q.size() > 0 && !is_stalled(frame_idx) && cyc + 1 >= rd_due_q[0]) begin
					off = int'(rd_addr_q.pop_front() - FB_BASE);
					void'(rd_due_q.pop_front());
					mem_data       <= (off < FRAME_WORDS) ? tests[off] : '0;
					mem_data_valid <= 1'b1;
				end
			end
		end
	end

	// Outputs are settled at the falling edge
	always @(negedge fbclk) begin
		track_reads();
		if (out_valid) begin
			if (out_x == 0 && out_y == V_ACTIVE && out_frame > 0) begin
				check_count("dvi_de", out_frame - 1, DE_PER_FRAME, de_cnt);
				check_count("dvi_hs", out_frame - 1, HS_PER_FRAME, hs_cnt);
				check_count("dvi_vs", out_frame - 1, VS_PER_FRAME, vs_cnt);
				de_cnt = 0;
				hs_cnt = 0;
				vs_cnt = 0;
			end
			if (out_frame == N_FRAMES) begin
				print_summary();
				if (total_errors() == 0) begin
					$display("TEST RESULT: PASS");
				end else begin
					$display("TEST RESULT: FAIL");
				end
				$finish;
			end else begin
				check_pixel();
			end
		end
	end

endmodule

/* framebuffer_tests.mem */
// Lines 0 to 15: frame words from FB_BASE up, first pixel in bits 63:40, second in bits 31:8
// Then one stall flag per test frame, 1 holds back every memory reply for that frame
102030a51121315a
122232a51323335a
142434a51525355a
162636a51727375a
182838a51929395a
1a2a3aa51b2b3b5a
1c2c3ca51d2d3d5a
1e2e3ea51f2f3f5a
405060c34151613c
425262c34353633c
445464c34555653c
465666c34757673c
485868c34959693c
4a5a6ac34b5b6b3c
4c5c6cc34d5d6d3c
4e5e6ec34f5f6f3c
// Stall flags for frames 0 to 5
0
0
1
0
1
0

/* framebuffer.f */
fb_pkg.sv
sync_gen.sv
pixel_fetch.sv
pixel_format.sv
framebuffer.sv
framebuffer_assert.sv
framebuffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the framebuffer testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --timing --timescale 1ns/100ps -Wno-fatal \
	--top-module framebuffer_tb -f framebuffer.f -o framebuffer_sim \
	&& ./obj_dir/framebuffer_sim +verilator+error+limit+1000 > sim.log 2>&1 \
	|| echo "Build or simulation run ended with an error"

cat sim.log 2>/dev/null
grep -q "^TEST RESULT: PASS$" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
